//--- floor_logic.f
+incdir+rtl
rtl/floor_logic_pkg.sv
rtl/button_latch.sv
rtl/floor_selector.sv
rtl/floor_logic_top.sv
bench/floor_logic_tb.sv

//--- run.sh
#!/bin/sh
# Builds the floor_logic testbench with Verilator and runs it.
# The exit status is that of the simulation.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f floor_logic.f \
    --top-module floor_logic_tb \
    --Mdir obj_dir \
    -o floor_logic_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/floor_logic_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

echo "Simulation finished cleanly"
exit 0

//--- bench/floor_logic_tb.sv
`timescale 1ns/1ns
`include "floor_logic_macros.svh"

module floor_logic_tb;
    import floor_logic_pkg::*;

    localparam int ROW_COUNT   = 8;
    localparam int BLOCK_COUNT = 8;
    localparam int DOOR_CASES  = 16;
    localparam int CAR_DELAY   = 3;
    // Each row needs priming, a press and up to two dispatches in well under 40 cycles
    localparam int TIMEOUT_CYCLES = ROW_COUNT * 40 + 20 + BLOCK_COUNT * 4 + DOOR_CASES * 2;

    typedef struct packed {
        floor_mask_t hall;
        floor_mask_t cab;
        floor_t      car_floor;
        logic        start_up;
        floor_t      exp_floor;
        logic        exp_up;
    } sweep_row_t;

    logic        clock;
    logic        reset_n;
    floor_mask_t hall_buttons;
    floor_mask_t cab_buttons;
    car_status_t car_status;
    logic        power_on;
    logic        emergency;
    logic        door_open_button;
    logic        door_close_button;
    logic        dispatch_ack;
    floor_mask_t hall_lights;
    floor_mask_t cab_lights;
    floor_t      target_floor;
    logic        travel_up;
    logic        dispatch_req;
    logic        door_open_allowed;
    logic        door_close_allowed;

    sweep_row_t  sweep_table [ROW_COUNT];
    logic [31:0] lcg_state;
    int          cycle_count;

    floor_logic_top floor_logic_top_inst (
        .clock              (clock),
        .reset_n            (reset_n),
        .hall_buttons       (hall_buttons),
        .cab_buttons        (cab_buttons),
        .car_status         (car_status),
        .power_on           (power_on),
        .emergency          (emergency),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .dispatch_ack       (dispatch_ack),
        .hall_lights        (hall_lights),
        .cab_lights         (cab_lights),
        .target_floor       (target_floor),
        .travel_up          (travel_up),
        .dispatch_req       (dispatch_req),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        lcg_next = state * 32'd1103515245 + 32'd12345;
    endfunction

    // Outputs are read and inputs driven 1 ns after the rising edge
    task automatic step_cycles(input int count);
        repeat (count) @(posedge clock);
        #1;
    endtask

    task automatic check_floor(input string name, input floor_t expected, input floor_t actual);
        if (expected !== actual) begin
            $display("Fail %s expected %0d actual %0d", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "Floor mismatch");
        end
    endtask

    task automatic check_mask(input string name, input floor_mask_t expected,
                              input floor_mask_t actual);
        if (expected !== actual) begin
            $display("Fail %s expected %03h actual %03h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "Mask mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("Fail %s expected %b actual %b", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "Bit mismatch");
        end
    endtask

    // Car controller model answering one dispatch with a four-phase handshake
    task automatic serve_dispatch(output floor_t target, output logic up);
        while (!dispatch_req) step_cycles(1);
        target = target_floor;
        up     = travel_up;
        car_status.car_moving = 1'b1;
        for (int i = 0; i < CAR_DELAY; i++) begin
            step_cycles(1);
            check_bit("request held while ack low", 1'b1, dispatch_req);
            check_floor("target held while ack low", target, target_floor);
        end
        car_status.car_floor  = target;
        car_status.car_moving = 1'b0;
        dispatch_ack          = 1'b1;
        while (dispatch_req) step_cycles(1);
        step_cycles(1);
        check_bit("no request while ack high", 1'b0, dispatch_req);
        check_bit("hall light cleared on arrival", 1'b0, hall_lights[target]);
        check_bit("cab light cleared on arrival", 1'b0, cab_lights[target]);
        dispatch_ack = 1'b0;
        step_cycles(1);
    endtask

    // A throwaway dispatch that leaves travel_up in the wanted direction
    task automatic set_direction(input logic up);
        floor_t target;
        logic   dir;
        if (travel_up != up) begin
            car_status.car_floor = up ? 4'd0 : 4'd10;
            step_cycles(1);
            hall_buttons = 11'h020;
            step_cycles(1);
            hall_buttons = '0;
            serve_dispatch(target, dir);
            check_bit("direction priming", up, dir);
        end
    endtask

    task automatic run_row(input int index);
        sweep_row_t  row;
        floor_mask_t here_mask;
        floor_t      target;
        logic        up;
        row       = sweep_table[index];
        here_mask = floor_mask_t'(1) << row.car_floor;
        set_direction(row.start_up);
        car_status.car_floor = row.car_floor;
        step_cycles(1);
        hall_buttons = row.hall;
        cab_buttons  = row.cab;
        step_cycles(1);
        hall_buttons = '0;
        cab_buttons  = '0;
        check_mask($sformatf("row %0d hall lights", index), row.hall & ~here_mask, hall_lights);
        check_mask($sformatf("row %0d cab lights", index), row.cab & ~here_mask, cab_lights);
        serve_dispatch(target, up);
        check_floor($sformatf("row %0d target", index), row.exp_floor, target);
        check_bit($sformatf("row %0d travel_up", index), row.exp_up, up);
        // Serve what is left so the next row starts with dark panels
        while ((hall_lights | cab_lights) != '0) serve_dispatch(target, up);
    endtask

    task automatic load_table();
        // hall mask, cab mask, car floor, start up, expected target, expected up
        sweep_table[0] = '{11'h008, 11'h080, 4'd0, 1'b1, 4'd3, 1'b1};
        sweep_table[1] = '{11'h100, 11'h040, 4'd5, 1'b1, 4'd6, 1'b1};
        sweep_table[2] = '{11'h004, 11'h200, 4'd5, 1'b0, 4'd2, 1'b0};
        // Nothing lit ahead so the sweep reverses
        sweep_table[3] = '{11'h010, 11'h000, 4'd10, 1'b1, 4'd4, 1'b0};
        sweep_table[4] = '{11'h000, 11'h040, 4'd0, 1'b0, 4'd6, 1'b1};
        // Press on the car floor is ignored
        sweep_table[5] = '{11'h012, 11'h000, 4'd4, 1'b1, 4'd1, 1'b0};
        sweep_table[6] = '{11'h000, 11'h280, 4'd7, 1'b0, 4'd9, 1'b1};
        sweep_table[7] = '{11'h400, 11'h001, 4'd3, 1'b0, 4'd0, 1'b0};
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        floor_t last_target;
        logic   last_up;
        reset_n           = 1'b0;
        hall_buttons      = '0;
        cab_buttons       = '0;
        car_status        = '0;
        power_on          = 1'b1;
        emergency         = 1'b0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        dispatch_ack      = 1'b0;
        cycle_count       = 0;
        lcg_state         = 32'd17;
        load_table();

        repeat (5) @(posedge clock);
        #1;
        check_mask("reset hall lights", '0, hall_lights);
        check_mask("reset cab lights", '0, cab_lights);
        check_bit("reset dispatch_req", 1'b0, dispatch_req);
        check_bit("reset door open permit", 1'b0, door_open_allowed);
        check_bit("reset door close permit", 1'b0, door_close_allowed);
        check_bit("reset travel_up", 1'b1, travel_up);
        check_floor("reset target_floor", 4'd0, target_floor);
        reset_n = 1'b1;
        step_cycles(1);

        for (int i = 0; i < ROW_COUNT; i++) begin
            run_row(i);
        end

        // Alternate between emergency and power loss
        for (int i = 0; i < BLOCK_COUNT; i++) begin
            emergency    = !i[0];
            power_on     = !i[0];
            lcg_state    = lcg_next(lcg_state);
            hall_buttons = floor_mask_t'(lcg_state[26:16]);
            lcg_state    = lcg_next(lcg_state);
            cab_buttons  = floor_mask_t'(lcg_state[26:16]);
            step_cycles(1);
            hall_buttons = '0;
            cab_buttons  = '0;
            step_cycles(2);
            check_mask($sformatf("blocked %0d hall lights", i), '0, hall_lights);
            check_mask($sformatf("blocked %0d cab lights", i), '0, cab_lights);
            check_bit($sformatf("blocked %0d dispatch_req", i), 1'b0, dispatch_req);
        end

        // A light taken before an emergency waits until the emergency ends
        power_on     = 1'b1;
        emergency    = 1'b0;
        hall_buttons = 11'h004;
        step_cycles(1);
        hall_buttons = '0;
        emergency    = 1'b1;
        step_cycles(3);
        check_mask("held hall light", 11'h004, hall_lights);
        check_bit("no dispatch while blocked", 1'b0, dispatch_req);
        emergency = 1'b0;
        serve_dispatch(last_target, last_up);
        check_floor("dispatch after unblock target", 4'd2, last_target);
        check_bit("dispatch after unblock travel_up", 1'b0, last_up);

        for (int i = 0; i < DOOR_CASES; i++) begin
            power_on              = i[0];
            car_status.car_moving = i[1];
            door_open_button      = i[2];
            door_close_button     = i[3];
            step_cycles(1);
            check_bit($sformatf("door case %0d open permit", i),
                      i[2] && i[0] && !i[1], door_open_allowed);
            check_bit($sformatf("door case %0d close permit", i),
                      i[3] && i[0] && !i[1], door_close_allowed);
        end
        power_on              = 1'b1;
        car_status.car_moving = 1'b0;
        door_open_button      = 1'b0;
        door_close_button     = 1'b0;
        step_cycles(1);

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- rtl/floor_logic_top.sv
`timescale 1ns/1ns

module floor_logic_top (
    input  logic                         clock,
    input  logic                         reset_n,
    input  floor_logic_pkg::floor_mask_t hall_buttons,
    input  floor_logic_pkg::floor_mask_t cab_buttons,
    input  floor_logic_pkg::car_status_t car_status,
    input  logic                         power_on,
    input  logic                         emergency,
    input  logic                         door_open_button,
    input  logic                         door_close_button,
    input  logic                         dispatch_ack,
    output floor_logic_pkg::floor_mask_t hall_lights,
    output floor_logic_pkg::floor_mask_t cab_lights,
    output floor_logic_pkg::floor_t      target_floor,
    output logic                         travel_up,
    output logic                         dispatch_req,
    output logic                         door_open_allowed,
    output logic                         door_close_allowed
);
    import floor_logic_pkg::*;

    logic     enable;
    logic     door_ok;
    arrival_t arrival;

    // Power off or emergency stops new requests and new dispatches
    assign enable = power_on && !emergency;

    //////////////////////////////
    // Button panels
    //////////////////////////////

    button_latch hall_latch (
        .clock      (clock),
        .reset_n    (reset_n),
        .buttons    (hall_buttons),
        .car_status (car_status),
        .accept     (enable),
        .arrival    (arrival),
        .lights     (hall_lights)
    );

    button_latch cab_latch (
        .clock      (clock),
        .reset_n    (reset_n),
        .buttons    (cab_buttons),
        .car_status (car_status),
        .accept     (enable),
        .arrival    (arrival),
        .lights     (cab_lights)
    );

    //////////////////////////////
    // Target selection
    //////////////////////////////

    floor_selector selector (
        .clock        (clock),
        .reset_n      (reset_n),
        .hall_lights  (hall_lights),
        .cab_lights   (cab_lights),
        .car_status   (car_status),
        .enable       (enable),
        .dispatch_ack (dispatch_ack),
        .dispatch_req (dispatch_req),
        .target_floor (target_floor),
        .travel_up    (travel_up),
        .arrival      (arrival)
    );

    //////////////////////////////
    // Door permits
    //////////////////////////////

    // Doors may only be worked on a powered car at rest
    assign door_ok = power_on && !car_status.car_moving;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= door_open_button && door_ok;
            door_close_allowed <= door_close_button && door_ok;
        end
    end

endmodule

//--- rtl/floor_selector.sv
`timescale 1ns/1ns
`include "floor_logic_macros.svh"

module floor_selector (
    input  logic                         clock,
    input  logic                         reset_n,
    input  floor_logic_pkg::floor_mask_t hall_lights,
    input  floor_logic_pkg::floor_mask_t cab_lights,
    input  floor_logic_pkg::car_status_t car_status,
    input  logic                         enable,
    input  logic                         dispatch_ack,
    output logic                         dispatch_req,
    output floor_logic_pkg::floor_t      target_floor,
    output logic                         travel_up,
    output floor_logic_pkg::arrival_t    arrival
);
    import floor_logic_pkg::*;

    floor_mask_t     pending;
    logic            here_lit;
    logic            above_found;
    logic            below_found;
    floor_t          above_floor;
    floor_t          below_floor;
    logic            pick_valid;
    floor_t          pick_floor;
    logic            pick_up;
    dispatch_state_e state;

    // Hall and cab requests are served alike
    assign pending = hall_lights | cab_lights;

    //////////////////////////////
    // Sweep target search
    //////////////////////////////

    always_comb begin
        here_lit    = 1'b0;
        above_found = 1'b0;
        below_found = 1'b0;
        above_floor = '0;
        below_floor = '0;
        // Scan downward so the last hit above the car is the nearest one
        for (int i = `FLOOR_COUNT - 1; i >= 0; i--) begin
            if (pending[i] && (floor_t'(i) > car_status.car_floor)) begin
                above_found = 1'b1;
                above_floor = floor_t'(i);
            end
        end
        // Scan upward so the last hit below the car is the nearest one
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            if (pending[i] && (floor_t'(i) < car_status.car_floor)) begin
                below_found = 1'b1;
                below_floor = floor_t'(i);
            end
            if (pending[i] && (floor_t'(i) == car_status.car_floor)) begin
                here_lit = 1'b1;
            end
        end
    end

    // Keep the current direction while work lies ahead, reverse otherwise
    always_comb begin
        pick_valid = 1'b1;
        pick_floor = car_status.car_floor;
        pick_up    = travel_up;
        if (here_lit) begin
            // Light left over at the floor the car reached, serve it in place
            pick_floor = car_status.car_floor;
        end else if (travel_up && above_found) begin
            pick_floor = above_floor;
            pick_up    = 1'b1;
        end else if (travel_up && below_found) begin
            pick_floor = below_floor;
            pick_up    = 1'b0;
        end else if (!travel_up && below_found) begin
            pick_floor = below_floor;
            pick_up    = 1'b0;
        end else if (!travel_up && above_found) begin
            pick_floor = above_floor;
            pick_up    = 1'b1;
        end else begin
            pick_valid = 1'b0;
        end
    end

    //////////////////////////////
    // Dispatch handshake FSM
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state        <= IDLE;
            dispatch_req <= 1'b0;
            target_floor <= '0;
            travel_up    <= 1'b1;
            arrival      <= '0;
        end else begin
            arrival.valid <= 1'b0;
            case (state)
                IDLE: begin
                    // Blocked only here, a raised request runs to completion
                    if (enable && pick_valid) begin
                        target_floor <= pick_floor;
                        travel_up    <= pick_up;
                        dispatch_req <= 1'b1;
                        state        <= REQUEST;
                    end
                end
                REQUEST: begin
                    // Car stands at the target, clear its lights in both panels
                    if (dispatch_ack) begin
                        dispatch_req  <= 1'b0;
                        arrival.valid <= 1'b1;
                        arrival.floor <= target_floor;
                        state         <= RELEASE;
                    end
                end
                RELEASE: begin
                    if (!dispatch_ack) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    req_holds_target : assert property (
        @(posedge clock) disable iff (!reset_n)
        (dispatch_req && $past(dispatch_req)) |-> ($stable(target_floor) && $stable(travel_up))
    ) else $error("Target changed during an open dispatch");

    // The car must have released the previous acknowledge first
    req_after_ack_low : assert property (
        @(posedge clock) disable iff (!reset_n)
        $rose(dispatch_req) |-> !$past(dispatch_ack)
    ) else $error("Dispatch raised while acknowledge was high");

endmodule

//--- rtl/button_latch.sv
`timescale 1ns/1ns
`include "floor_logic_macros.svh"

module button_latch (
    input  logic                         clock,
    input  logic                         reset_n,
    input  floor_logic_pkg::floor_mask_t buttons,
    input  floor_logic_pkg::car_status_t car_status,
    input  logic                         accept,
    input  floor_logic_pkg::arrival_t    arrival,
    output floor_logic_pkg::floor_mask_t lights
);
    import floor_logic_pkg::*;

    floor_mask_t here_mask;
    floor_mask_t clear_mask;
    floor_mask_t set_mask;
    floor_mask_t lights_next;

    //////////////////////////////
    // Floor decode
    //////////////////////////////

    // One-hot masks for the floor the car stands at and the arrived floor
    always_comb begin
        here_mask  = '0;
        clear_mask = '0;
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            if (car_status.car_floor == floor_t'(i)) begin
                here_mask[i] = 1'b1;
            end
            if (arrival.valid && (arrival.floor == floor_t'(i))) begin
                clear_mask[i] = 1'b1;
            end
        end
    end

    //////////////////////////////
    // Light registers
    //////////////////////////////

    // Presses for the current floor are dropped since the doors serve them directly
    assign set_mask = accept ? (buttons & ~here_mask) : '0;

    // Arrival clear overrides a same-cycle press
    assign lights_next = (lights | set_mask) & ~clear_mask;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= '0;
        end else begin
            lights <= lights_next;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // A new light never appears for the floor the car stood at when it was latched
    light_not_at_car_floor : assert property (
        @(posedge clock) disable iff (!reset_n)
        ($past(car_status.car_floor) < floor_t'(`FLOOR_COUNT)) |->
            !(lights[$past(car_status.car_floor)] && !$past(lights[car_status.car_floor]))
    ) else $error("Light raised for the floor of the car");

endmodule

//--- rtl/floor_logic_pkg.sv
`include "floor_logic_macros.svh"

package floor_logic_pkg;

    // Floor number, 0 is the ground floor
    typedef logic [`FLOOR_WIDTH-1:0] floor_t;

    // One bit per floor, bit i stands for floor i
    typedef logic [`FLOOR_COUNT-1:0] floor_mask_t;

    // Dispatch handshake states of the selector
    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        RELEASE
    } dispatch_state_e;

    // Position report from the car controller
    typedef struct packed {
        floor_t car_floor;
        logic   car_moving;
    } car_status_t;

    // Clear order sent to both button latches
    typedef struct packed {
        logic   valid;
        floor_t floor;
    } arrival_t;

endpackage

//--- rtl/floor_logic_macros.svh
`ifndef FLOOR_LOGIC_MACROS_SVH
`define FLOOR_LOGIC_MACROS_SVH

//////////////////////////////
// Building geometry
//////////////////////////////

// Floors served by the car, ground floor is 0
`define FLOOR_COUNT 11

// Bits needed to hold a floor number up to FLOOR_COUNT - 1
`define FLOOR_WIDTH 4

`endif
